//--- bench/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

   import soc_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int VEC_FIELDS   = 7;
   localparam int VEC_MAX      = 64;
   localparam int RANDOM_WORDS = 64;
   localparam int ACK_LIMIT    = 8;
   localparam int TIMER_WAIT   = 60;
   // Every vector, random write and both random reads, plus the directed accesses.
   localparam int TIMEOUT_CYCLES = (VEC_MAX + 3 * RANDOM_WORDS + 16) * 10 + TIMER_WAIT + 50;

   logic wb_clk;
   logic i_rst_n;
   adr_t i_ibus_adr;
   logic i_ibus_cyc;
   dat_t o_ibus_rdt;
   logic o_ibus_ack;
   adr_t i_dbus_adr;
   dat_t i_dbus_dat;
   sel_t i_dbus_sel;
   logic i_dbus_we;
   logic i_dbus_cyc;
   dat_t o_dbus_rdt;
   logic o_dbus_ack;
   logic o_gpio;
   logic o_timer_irq;

   logic [31:0] vec_mem [VEC_MAX*VEC_FIELDS];
   dat_t        model_mem [RAM_WORDS];
   logic [31:0] rng;

   soc_top uut (
      .wb_clk      (wb_clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_adr  (i_ibus_adr),
      .i_ibus_cyc  (i_ibus_cyc),
      .o_ibus_rdt  (o_ibus_rdt),
      .o_ibus_ack  (o_ibus_ack),
      .i_dbus_adr  (i_dbus_adr),
      .i_dbus_dat  (i_dbus_dat),
      .i_dbus_sel  (i_dbus_sel),
      .i_dbus_we   (i_dbus_we),
      .i_dbus_cyc  (i_dbus_cyc),
      .o_dbus_rdt  (o_dbus_rdt),
      .o_dbus_ack  (o_dbus_ack),
      .o_gpio      (o_gpio),
      .o_timer_irq (o_timer_irq)
   );

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD/2) wb_clk = ~wb_clk;
   end

   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic fail_value(input string sig, input logic [31:0] got,
                             input logic [31:0] expected);
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, sig, got, expected);
      abort_run();
   endtask

   task automatic fail_text(input string what);
      $display("** Error at %0t: %s", $time, what);
      abort_run();
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic adr_t word_adr(input logic [RAM_AW-1:0] idx);
      return {{(32-RAM_AW-2){1'b0}}, idx, 2'b00};
   endfunction

   // A fetch never waits, so its ack always lands two samples after cyc goes up.
   task automatic ibus_read(input adr_t adr, output dat_t rdt);
      int cycles;
      @(posedge wb_clk);
      i_ibus_adr <= adr;
      i_ibus_cyc <= 1'b1;
      cycles = 0;
      do begin
         @(negedge wb_clk);
         cycles++;
         assert (cycles <= ACK_LIMIT) else fail_text("instruction ack never arrived");
      end while (!o_ibus_ack);
      rdt = o_ibus_rdt;
      assert (cycles == 2) else fail_value("o_ibus_ack latency", cycles, 32'd2);
      @(posedge wb_clk);
      i_ibus_cyc <= 1'b0;
      @(negedge wb_clk);
      assert (!o_ibus_ack) else fail_value("o_ibus_ack", {31'd0, o_ibus_ack}, 32'd0);
   endtask

   task automatic dbus_access(input adr_t adr, input dat_t dat, input sel_t sel,
                              input logic we, input int exp_cycles, output dat_t rdt);
      int cycles;
      @(posedge wb_clk);
      i_dbus_adr <= adr;
      i_dbus_dat <= dat;
      i_dbus_sel <= sel;
      i_dbus_we  <= we;
      i_dbus_cyc <= 1'b1;
      cycles = 0;
      do begin
         @(negedge wb_clk);
         cycles++;
         assert (cycles <= ACK_LIMIT) else fail_text("data ack never arrived");
      end while (!o_dbus_ack);
      rdt = o_dbus_rdt;
      assert (cycles == exp_cycles) else fail_value("o_dbus_ack latency", cycles, exp_cycles);
      @(posedge wb_clk);
      i_dbus_cyc <= 1'b0;
      @(negedge wb_clk);
      assert (!o_dbus_ack) else fail_value("o_dbus_ack", {31'd0, o_dbus_ack}, 32'd0);
   endtask

   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge wb_clk);
         assert (!o_ibus_ack) else fail_value("o_ibus_ack", {31'd0, o_ibus_ack}, 32'd0);
         assert (!o_dbus_ack) else fail_value("o_dbus_ack", {31'd0, o_dbus_ack}, 32'd0);
         assert (!o_gpio) else fail_value("o_gpio", {31'd0, o_gpio}, 32'd0);
         assert (!o_timer_irq) else fail_value("o_timer_irq", {31'd0, o_timer_irq}, 32'd0);
      end
   endtask

   task automatic play_vectors();
      int          n;
      int          base;
      dat_t        rdt;
      logic [31:0] expected;
      logic [31:0] mask;
      string       sig;
      n = 0;
      base = 0;
      while (vec_mem[base] != 32'hf) begin
         assert (n < VEC_MAX) else fail_text("vector file has no end marker");
         expected = vec_mem[base+5];
         mask     = vec_mem[base+6];
         if (vec_mem[base] == 32'h0) begin
            ibus_read(vec_mem[base+3], rdt);
            sig = "o_ibus_rdt";
         end else begin
            dbus_access(vec_mem[base+3], vec_mem[base+4], vec_mem[base+2][3:0],
                        vec_mem[base+1][0], 2, rdt);
            sig = "o_dbus_rdt";
         end
         assert ((rdt & mask) == (expected & mask)) else fail_value(sig, rdt, expected);
         if (vec_mem[base+1][0] && vec_mem[base+3][31:30] == REGION_GPIO) begin
            assert (o_gpio == vec_mem[base+4][0])               // Pin follows data bit 0.
               else fail_value("o_gpio", {31'd0, o_gpio}, {31'd0, vec_mem[base+4][0]});
         end
         n++;
         base += VEC_FIELDS;
      end
   endtask

   task automatic priority_test();
      dat_t ird;
      dat_t drd;
      dat_t discard;
      dbus_access(32'h0000_0200, 32'h600d_f00d, 4'hf, 1'b1, 2, discard);
      dbus_access(32'h0000_0300, 32'h1357_9bdf, 4'hf, 1'b1, 2, discard);
      // Both masters start in the same cycle. The data read waits for the fetch.
      fork
         ibus_read(32'h0000_0200, ird);
         dbus_access(32'h0000_0300, 32'h0, 4'hf, 1'b0, 4, drd);
      join
      assert (ird == 32'h600d_f00d) else fail_value("o_ibus_rdt", ird, 32'h600d_f00d);
      assert (drd == 32'h1357_9bdf) else fail_value("o_dbus_rdt", drd, 32'h1357_9bdf);
      // A held-off write must not land at the fetch address.
      fork
         ibus_read(32'h0000_0200, ird);
         dbus_access(32'h0000_0300, 32'h2468_ace0, 4'hf, 1'b1, 4, discard);
      join
      assert (ird == 32'h600d_f00d) else fail_value("o_ibus_rdt", ird, 32'h600d_f00d);
      dbus_access(32'h0000_0200, 32'h0, 4'hf, 1'b0, 2, drd);
      assert (drd == 32'h600d_f00d) else fail_value("o_dbus_rdt", drd, 32'h600d_f00d);
      dbus_access(32'h0000_0300, 32'h0, 4'hf, 1'b0, 2, drd);
      assert (drd == 32'h2468_ace0) else fail_value("o_dbus_rdt", drd, 32'h2468_ace0);
   endtask

   task automatic random_ram_test();
      logic [RAM_AW-1:0] idx [RANDOM_WORDS];
      dat_t              data;
      dat_t              rdt;
      for (int i = 0; i < RANDOM_WORDS; i++) begin
         rng = xorshift32(rng);
         idx[i] = rng[RAM_AW-1:0];
         rng = xorshift32(rng);
         data = rng;
         model_mem[idx[i]] = data;                         // Repeated addresses keep the last.
         dbus_access(word_adr(idx[i]), data, 4'hf, 1'b1, 2, rdt);
      end
      for (int i = 0; i < RANDOM_WORDS; i++) begin
         ibus_read(word_adr(idx[i]), rdt);
         assert (rdt == model_mem[idx[i]]) else fail_value("o_ibus_rdt", rdt, model_mem[idx[i]]);
         dbus_access(word_adr(idx[i]), 32'h0, 4'hf, 1'b0, 2, rdt);
         assert (rdt == model_mem[idx[i]]) else fail_value("o_dbus_rdt", rdt, model_mem[idx[i]]);
      end
   endtask

   task automatic timer_test();
      adr_t base;
      dat_t m;
      dat_t now;
      dat_t discard;
      base = {REGION_TIMER, 30'd0};
      dbus_access(base | TIMER_MTIME_OFS, 32'h0, 4'hf, 1'b0, 2, m);
      dbus_access(base | TIMER_CMP_OFS, m + 32'd50, 4'hf, 1'b1, 2, discard);
      assert (!o_timer_irq) else fail_value("o_timer_irq", {31'd0, o_timer_irq}, 32'd0);
      repeat (TIMER_WAIT) @(negedge wb_clk);
      assert (o_timer_irq) else fail_value("o_timer_irq", {31'd0, o_timer_irq}, 32'd1);
      dbus_access(base | TIMER_MTIME_OFS, 32'h0, 4'hf, 1'b0, 2, now);
      assert (now >= m + 32'd50) else fail_value("mtime", now, m + 32'd50);
      dbus_access(base | TIMER_CMP_OFS, 32'h0, 4'hf, 1'b0, 2, now);
      assert (now == m + 32'd50) else fail_value("mtimecmp", now, m + 32'd50);
   endtask

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      fail_text("watchdog expired before the tests finished");
   end

   initial begin
      i_rst_n    = 1'b0;
      i_ibus_adr = '0;
      i_ibus_cyc = 1'b0;
      i_dbus_adr = '0;
      i_dbus_dat = '0;
      i_dbus_sel = '0;
      i_dbus_we  = 1'b0;
      i_dbus_cyc = 1'b0;
      rng = 32'd32;
      $readmemh("bench/soc_vectors.hex", vec_mem);
      repeat (2) @(posedge wb_clk);
      i_rst_n <= 1'b1;
      check_idle(4);
      play_vectors();
      priority_test();
      random_ram_test();
      timer_test();
      @(negedge wb_clk);
      $display("All tests passed");
      $finish;
   end

endmodule

//--- bench/soc_vectors.hex
// port we sel address wdata expected mask
// Port 0 is the instruction bus, 1 the data bus. A zero mask skips the compare.
// Byte lanes on word 0x100.
1 1 f 00000100 11223344 00000000 00000000
1 0 f 00000100 00000000 11223344 ffffffff
1 1 1 00000100 556677aa 00000000 00000000
1 0 f 00000100 00000000 112233aa ffffffff
1 1 8 00000100 bb998877 00000000 00000000
0 0 f 00000100 00000000 bb2233aa ffffffff
1 1 6 00000100 12ccdd34 00000000 00000000
1 0 f 00000100 00000000 bbccddaa ffffffff
// Last RAM word.
1 1 f 00001ffc deadbeef 00000000 00000000
1 1 3 00001ffc 0000cafe 00000000 00000000
0 0 f 00001ffc 00000000 deadcafe ffffffff
1 1 c 00001ffc 1234ffff 00000000 00000000
1 0 f 00001ffc 00000000 1234cafe ffffffff
// Alternating lanes on word 0x4.
1 1 f 00000004 a5a5a5a5 00000000 00000000
1 1 5 00000004 00ff00ff 00000000 00000000
1 0 f 00000004 00000000 a5ffa5ff ffffffff
1 1 a 00000004 77007700 00000000 00000000
0 0 f 00000004 00000000 77ff77ff ffffffff
// GPIO pin, written through the data bus and read from both ports.
1 1 1 40000000 00000001 00000000 00000000
1 0 f 40000000 00000000 00000001 ffffffff
0 0 f 40000000 00000000 00000001 ffffffff
1 1 1 40000000 fffffffe 00000000 00000000
1 0 f 40000000 00000000 00000000 ffffffff
0 0 f 40000000 00000000 00000000 ffffffff
// Unmapped region reads zero and leaves the RAM alone.
1 0 f c0000100 00000000 00000000 ffffffff
1 1 f c0000100 0badf00d 00000000 00000000
1 0 f 00000100 00000000 bbccddaa ffffffff
1 1 f c0001ffc 0badf00d 00000000 00000000
0 0 f c0001ffc 00000000 00000000 ffffffff
0 0 f 00001ffc 00000000 1234cafe ffffffff
// mtimecmp comes out of reset as all ones.
1 0 f 80000004 00000000 ffffffff ffffffff
// End marker.
f 0 0 00000000 00000000 00000000 00000000

//--- build.f
hdl/soc_pkg.sv
hdl/soc_arbiter.sv
hdl/soc_mux.sv
hdl/soc_ram.sv
hdl/soc_timer.sv
hdl/soc_top.sv
bench/soc_tb.sv

//--- hdl/soc_arbiter.sv
`timescale 1ns/1ps

module soc_arbiter (
   input  soc_pkg::adr_t i_ibus_adr,
   input  logic          i_ibus_cyc,
   output soc_pkg::dat_t o_ibus_rdt,
   output logic          o_ibus_ack,

   input  soc_pkg::adr_t i_dbus_adr,
   input  soc_pkg::dat_t i_dbus_dat,
   input  soc_pkg::sel_t i_dbus_sel,
   input  logic          i_dbus_we,
   input  logic          i_dbus_cyc,
   output soc_pkg::dat_t o_dbus_rdt,
   output logic          o_dbus_ack,

   output soc_pkg::adr_t o_cpu_adr,
   output soc_pkg::dat_t o_cpu_dat,
   output soc_pkg::sel_t o_cpu_sel,
   output logic          o_cpu_we,
   output logic          o_cpu_cyc,
   input  soc_pkg::dat_t i_cpu_rdt,
   input  logic          i_cpu_ack
);

   // The instruction port owns the bus for as long as its cyc is high.
   assign o_cpu_adr = i_ibus_cyc ? i_ibus_adr : i_dbus_adr;
   assign o_cpu_dat = i_dbus_dat;                     // Fetches never write.
   assign o_cpu_sel = i_ibus_cyc ? '1 : i_dbus_sel;
   assign o_cpu_we  = i_dbus_we & ~i_ibus_cyc;
   assign o_cpu_cyc = i_ibus_cyc | i_dbus_cyc;

   // Both masters see the read data, only the selected one sees the ack.
   assign o_ibus_rdt = i_cpu_rdt;
   assign o_dbus_rdt = i_cpu_rdt;

   assign o_ibus_ack = i_cpu_ack & i_ibus_cyc;
   assign o_dbus_ack = i_cpu_ack & ~i_ibus_cyc;

   // A data ack has to close a data request that was still pending,
   // with no fetch holding the bus at that moment.
   a_dbus_ack_owner : assert property (
      @(posedge o_dbus_ack) i_dbus_cyc && !i_ibus_cyc
   ) else $error("dbus ack without an open dbus request or during a fetch");

endmodule

//--- hdl/soc_mux.sv
`timescale 1ns/1ps

module soc_mux (
   input  logic                          wb_clk,
   input  logic                          i_rst_n,

   input  soc_pkg::adr_t                 i_cpu_adr,
   input  soc_pkg::dat_t                 i_cpu_dat,
   input  soc_pkg::sel_t                 i_cpu_sel,
   input  logic                          i_cpu_we,
   input  logic                          i_cpu_cyc,
   output soc_pkg::dat_t                 o_cpu_rdt,
   output logic                          o_cpu_ack,

   output logic [soc_pkg::RAM_AW-1:0]    o_mem_adr,
   output soc_pkg::dat_t                 o_mem_dat,
   output soc_pkg::sel_t                 o_mem_sel,
   output logic                          o_mem_we,
   output logic                          o_mem_cyc,
   input  soc_pkg::dat_t                 i_mem_rdt,

   output logic                          o_timer_adr,
   output soc_pkg::dat_t                 o_timer_dat,
   output logic                          o_timer_we,
   output logic                          o_timer_cyc,
   input  soc_pkg::dat_t                 i_timer_rdt,

   output logic                          o_gpio
);

   import soc_pkg::*;

   logic [1:0] region;
   logic       ack_q;
   logic       gpio_q;

   assign region = i_cpu_adr[31:30];

   // RAM side. The byte address drops its two lane bits.
   assign o_mem_adr = i_cpu_adr[RAM_AW+1:2];
   assign o_mem_dat = i_cpu_dat;
   assign o_mem_sel = i_cpu_sel;
   assign o_mem_we  = i_cpu_we;
   assign o_mem_cyc = i_cpu_cyc & (region == REGION_MEM);

   // Timer side. Address bit 2 tells mtime from mtimecmp.
   assign o_timer_adr = i_cpu_adr[2];
   assign o_timer_dat = i_cpu_dat;
   assign o_timer_we  = i_cpu_we;
   assign o_timer_cyc = i_cpu_cyc & (region == REGION_TIMER);

   // One ack per access. It drops at the next edge even if cyc is still held.
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_cpu_cyc & ~ack_q;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         gpio_q <= 1'b0;
      end else if (i_cpu_cyc && i_cpu_we && region == REGION_GPIO) begin
         gpio_q <= i_cpu_dat[0];
      end
   end

   // The address is held for the whole access, so the current region steers.
   always_comb begin
      case (region)
         REGION_MEM:   o_cpu_rdt = i_mem_rdt;
         REGION_GPIO:  o_cpu_rdt = {31'd0, gpio_q};
         REGION_TIMER: o_cpu_rdt = i_timer_rdt;
         default:      o_cpu_rdt = '0;             // Unmapped reads as zero.
      endcase
   end

   assign o_cpu_ack = ack_q;
   assign o_gpio    = gpio_q;

   a_single_ack : assert property (
      @(posedge wb_clk) disable iff (!i_rst_n) o_cpu_ack |=> !o_cpu_ack
   ) else $error("cpu ack high on two consecutive cycles");

endmodule

//--- hdl/soc_pkg.sv
package soc_pkg;

   // Bus field widths.
   typedef logic [31:0] adr_t;
   typedef logic [31:0] dat_t;
   typedef logic [3:0]  sel_t;

   // RAM geometry, counted in 32-bit words.
   localparam int RAM_WORDS = 2048;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   // Address bits 31 to 30 pick the target. Code 3 is unmapped.
   localparam logic [1:0] REGION_MEM   = 2'd0;
   localparam logic [1:0] REGION_GPIO  = 2'd1;
   localparam logic [1:0] REGION_TIMER = 2'd2;

   // Byte offsets of the timer registers.
   localparam adr_t TIMER_MTIME_OFS = 32'h0000_0000;
   localparam adr_t TIMER_CMP_OFS   = 32'h0000_0004;

endpackage

//--- hdl/soc_ram.sv
`timescale 1ns/1ps

module soc_ram (
   input  logic                       wb_clk,
   input  logic [soc_pkg::RAM_AW-1:0] i_adr,
   input  soc_pkg::dat_t              i_dat,
   input  soc_pkg::sel_t              i_sel,
   input  logic                       i_we,
   input  logic                       i_cyc,
   output soc_pkg::dat_t              o_rdt
);

   import soc_pkg::*;

   dat_t mem [RAM_WORDS];

   // Each set lane writes its own byte, the other bytes keep their value.
   always_ff @(posedge wb_clk) begin
      if (i_cyc && i_we) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (i_sel[lane]) begin
               mem[i_adr][lane*8 +: 8] <= i_dat[lane*8 +: 8];
            end
         end
      end
   end

   // Read data is ready in the cycle that carries the ack.
   always_ff @(posedge wb_clk) begin
      if (i_cyc) begin
         o_rdt <= mem[i_adr];
      end
   end

   // An undefined lane mask would corrupt neighbouring bytes.
   a_sel_known : assert property (
      @(posedge wb_clk) i_cyc |-> !$isunknown(i_sel)
   ) else $error("ram sel has unknown bits during an access");

endmodule

//--- hdl/soc_timer.sv
`timescale 1ns/1ps

module soc_timer (
   input  logic          wb_clk,
   input  logic          i_rst_n,
   input  logic          i_adr,
   input  soc_pkg::dat_t i_dat,
   input  logic          i_we,
   input  logic          i_cyc,
   output soc_pkg::dat_t o_rdt,
   output logic          o_irq
);

   import soc_pkg::*;

   dat_t mtime;
   dat_t mtimecmp;

   // i_adr is byte address bit 2.
   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 32'd1;                    // Not writable from the bus.
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         mtimecmp <= '1;
      end else if (i_cyc && i_we && i_adr == TIMER_CMP_OFS[2]) begin
         mtimecmp <= i_dat;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (!i_rst_n) begin
         o_irq <= 1'b0;
      end else begin
         o_irq <= (mtime >= mtimecmp);
      end
   end

   assign o_rdt = (i_adr == TIMER_MTIME_OFS[2]) ? mtime : mtimecmp;

endmodule

//--- hdl/soc_top.sv
`timescale 1ns/1ps

module soc_top (
   input  logic          wb_clk,
   input  logic          i_rst_n,

   input  soc_pkg::adr_t i_ibus_adr,
   input  logic          i_ibus_cyc,
   output soc_pkg::dat_t o_ibus_rdt,
   output logic          o_ibus_ack,

   input  soc_pkg::adr_t i_dbus_adr,
   input  soc_pkg::dat_t i_dbus_dat,
   input  soc_pkg::sel_t i_dbus_sel,
   input  logic          i_dbus_we,
   input  logic          i_dbus_cyc,
   output soc_pkg::dat_t o_dbus_rdt,
   output logic          o_dbus_ack,

   output logic          o_gpio,
   output logic          o_timer_irq
);

   import soc_pkg::*;

   // Merged CPU bus.
   adr_t cpu_adr;
   dat_t cpu_dat;
   sel_t cpu_sel;
   logic cpu_we;
   logic cpu_cyc;
   dat_t cpu_rdt;
   logic cpu_ack;

   logic [RAM_AW-1:0] mem_adr;
   dat_t              mem_dat;
   sel_t              mem_sel;
   logic              mem_we;
   logic              mem_cyc;
   dat_t              mem_rdt;

   logic timer_adr;
   dat_t timer_dat;
   logic timer_we;
   logic timer_cyc;
   dat_t timer_rdt;

   soc_arbiter arbiter (
      .i_ibus_adr (i_ibus_adr),
      .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt),
      .o_ibus_ack (o_ibus_ack),
      .i_dbus_adr (i_dbus_adr),
      .i_dbus_dat (i_dbus_dat),
      .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),
      .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt),
      .o_dbus_ack (o_dbus_ack),
      .o_cpu_adr  (cpu_adr),
      .o_cpu_dat  (cpu_dat),
      .o_cpu_sel  (cpu_sel),
      .o_cpu_we   (cpu_we),
      .o_cpu_cyc  (cpu_cyc),
      .i_cpu_rdt  (cpu_rdt),
      .i_cpu_ack  (cpu_ack)
   );

   soc_mux mux (
      .wb_clk      (wb_clk),
      .i_rst_n     (i_rst_n),
      .i_cpu_adr   (cpu_adr),
      .i_cpu_dat   (cpu_dat),
      .i_cpu_sel   (cpu_sel),
      .i_cpu_we    (cpu_we),
      .i_cpu_cyc   (cpu_cyc),
      .o_cpu_rdt   (cpu_rdt),
      .o_cpu_ack   (cpu_ack),
      .o_mem_adr   (mem_adr),
      .o_mem_dat   (mem_dat),
      .o_mem_sel   (mem_sel),
      .o_mem_we    (mem_we),
      .o_mem_cyc   (mem_cyc),
      .i_mem_rdt   (mem_rdt),
      .o_timer_adr (timer_adr),
      .o_timer_dat (timer_dat),
      .o_timer_we  (timer_we),
      .o_timer_cyc (timer_cyc),
      .i_timer_rdt (timer_rdt),
      .o_gpio      (o_gpio)
   );

   soc_ram ram (
      .wb_clk (wb_clk),
      .i_adr  (mem_adr),
      .i_dat  (mem_dat),
      .i_sel  (mem_sel),
      .i_we   (mem_we),
      .i_cyc  (mem_cyc),
      .o_rdt  (mem_rdt)
   );

   soc_timer timer (
      .wb_clk  (wb_clk),
      .i_rst_n (i_rst_n),
      .i_adr   (timer_adr),
      .i_dat   (timer_dat),
      .i_we    (timer_we),
      .i_cyc   (timer_cyc),
      .o_rdt   (timer_rdt),
      .o_irq   (o_timer_irq)
   );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f build.f --top-module soc_tb -o soc_sim &&
./obj_dir/soc_sim || exit 1
